//--- verilog/loadAlignPkg.sv
package loadAlignPkg;

    localparam int LINE_BYTES = 16;

    typedef logic [14:0]  pAddr_t;  // Physical byte address.
    typedef logic [127:0] line_t;
    typedef logic [15:0]  byteEn_t;
    typedef logic [31:0]  word_t;   // APB data word.
    typedef logic [63:0]  result_t;
    typedef logic [9:0]   row_t;    // Widest row a 15-bit address allows.
    typedef logic [1:0]   loadSize_t;

    // Size codes.
    localparam loadSize_t sizeByte   = 2'd0;
    localparam loadSize_t sizeHalf   = 2'd1;
    localparam loadSize_t sizeWord   = 2'd2;
    localparam loadSize_t sizeDouble = 2'd3;

    typedef struct packed {
        pAddr_t    pAddr;
        loadSize_t size;
        logic      signExt;
    } loadReq_t;

    typedef struct packed {
        logic    write;
        row_t    row;
        line_t   wdata;
        byteEn_t byteEn;
    } bankReq_t;

    typedef struct packed {
        logic [3:0] offset;
        loadSize_t  size;
        logic       signExt;
        logic       needP1;   // Load runs into the next line.
        logic       oddFirst; // Odd bank holds the address line.
    } alignCtl_t;

    typedef enum logic {
        ownerLoad,
        ownerApb
    } owner_t;

    typedef enum logic [1:0] {
        apbIdle,
        apbWait,
        apbDone
    } apbState_t;

endpackage

//--- verilog/lineBank.sv
module lineBank
    import loadAlignPkg::*;
#(
    parameter int bankLines = 64
) (
    input  logic     clk,
    input  bankReq_t req,
    input  logic     reqValid,
    output line_t    rdata
);

    localparam int rowBits = $clog2(bankLines);

    line_t mem [bankLines];
    logic [rowBits-1:0] rowIdx;

    assign rowIdx = req.row[rowBits-1:0];

    always_ff @(posedge clk) begin
        if (reqValid) begin
            if (req.write) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (req.byteEn[b]) begin
                        mem[rowIdx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[rowIdx]; // Data shows up the next cycle.
            end
        end
    end

endmodule

//--- verilog/bankArbiter.sv
module bankArbiter
    import loadAlignPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     loadAsk,
    input  logic     apbAsk,
    input  bankReq_t loadEven,
    input  bankReq_t loadOdd,
    input  bankReq_t apbEven,
    input  bankReq_t apbOdd,
    output logic     loadGrant,
    output logic     apbGrant,
    output bankReq_t evenReq,
    output bankReq_t oddReq,
    output logic     evenValid,
    output logic     oddValid
);

    owner_t lastOwner;

    // Both asking means the side that lost last time goes first.
    always_comb begin
        loadGrant = loadAsk && (!apbAsk || lastOwner == ownerApb);
        apbGrant  = apbAsk && !loadGrant;
    end

    always_comb begin
        evenReq   = loadGrant ? loadEven : apbEven;
        oddReq    = loadGrant ? loadOdd : apbOdd;
        evenValid = loadGrant || apbGrant;
        oddValid  = loadGrant || apbGrant;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lastOwner <= ownerApb; // Loads win the first tie.
        end else if (loadGrant) begin
            lastOwner <= ownerLoad;
        end else if (apbGrant) begin
            lastOwner <= ownerApb;
        end
    end

endmodule

//--- verilog/apbLineFill.sv
module apbLineFill
    import loadAlignPkg::*;
#(
    parameter int bankLines = 64
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     PSEL,
    input  logic     PENABLE,
    input  logic     PWRITE,
    input  word_t    PADDR,
    input  word_t    PWDATA,
    output word_t    PRDATA,
    output logic     PREADY,
    output logic     PSLVERR,
    output logic     apbAsk,
    input  logic     apbGrant,
    output bankReq_t apbEven,
    output bankReq_t apbOdd,
    input  line_t    evenData,
    input  line_t    oddData
);

    localparam int storeBytes = 2 * bankLines * LINE_BYTES;

    apbState_t state;
    pAddr_t    byteAddr;
    logic      access;
    logic      inRange;
    logic      oddBank;
    logic [1:0] wordSel;
    bankReq_t  req;
    line_t     bankLine;
    word_t     readWord;

    assign byteAddr = PADDR[14:0];
    assign access   = PSEL && PENABLE;
    assign inRange  = PADDR < word_t'(storeBytes);
    assign oddBank  = byteAddr[4];
    assign wordSel  = byteAddr[3:2];
    assign bankLine = oddBank ? oddData : evenData;

    // Ask only while idle in the access phase.
    assign apbAsk  = (state == apbIdle) && access && inRange;
    assign PSLVERR = (state == apbIdle) && access && !inRange;
    assign PREADY  = (state == apbDone) || PSLVERR;
    assign PRDATA  = (state == apbDone && !PWRITE) ? readWord : '0;

    always_comb begin
        req.write  = PWRITE;
        req.row    = row_t'(byteAddr[14:5] % bankLines);
        req.wdata  = {4{PWDATA}};
        req.byteEn = byteEn_t'(16'h000f << (4 * wordSel));
        apbEven    = req;
        apbOdd     = req;
        if (oddBank) begin
            apbEven.byteEn = '0;
        end else begin
            apbOdd.byteEn = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= apbIdle;
        end else begin
            case (state)
                apbIdle: if (apbAsk && apbGrant) state <= PWRITE ? apbDone : apbWait;
                apbWait: state <= apbDone; // Bank line is back.
                default: state <= apbIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == apbWait) begin
            readWord <= bankLine[32*wordSel +: 32];
        end
    end

endmodule

//--- verilog/loadIssue.sv
module loadIssue
    import loadAlignPkg::*;
#(
    parameter int bankLines = 64
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      loadValid,
    input  loadReq_t  loadReq,
    output logic      loadReady,
    output logic      loadAsk,
    input  logic      loadGrant,
    output bankReq_t  loadEven,
    output bankReq_t  loadOdd,
    output alignCtl_t ctl,
    output logic      ctlValid
);

    pAddr_t    addr;
    logic [10:0] line;
    logic [10:0] nextLine;
    logic [10:0] evenLine;
    logic [10:0] oddLine;
    logic [4:0]  byteCount;
    alignCtl_t   nextCtl;

    assign addr      = loadReq.pAddr;
    assign line      = addr[14:4];
    assign nextLine  = line + 11'd1;
    assign byteCount = 5'd1 << loadReq.size;

    // One of the pair is even and the other odd.
    assign evenLine = line[0] ? nextLine : line;
    assign oddLine  = line[0] ? line : nextLine;

    always_comb begin
        nextCtl.offset   = addr[3:0];
        nextCtl.size     = loadReq.size;
        nextCtl.signExt  = loadReq.signExt;
        nextCtl.needP1   = ({1'b0, addr[3:0]} + byteCount) > LINE_BYTES;
        nextCtl.oddFirst = line[0];
    end

    always_comb begin
        loadEven.write  = 1'b0;
        loadEven.row    = row_t'((evenLine >> 1) % bankLines);
        loadEven.wdata  = '0;
        loadEven.byteEn = '0;
        loadOdd.write   = 1'b0;
        loadOdd.row     = row_t'((oddLine >> 1) % bankLines);
        loadOdd.wdata   = '0;
        loadOdd.byteEn  = '0;
    end

    assign loadAsk   = loadValid;
    assign loadReady = loadGrant;

    // Lines up with the bank data one cycle later.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctlValid <= 1'b0;
        end else begin
            ctlValid <= loadValid && loadGrant;
        end
    end

    always_ff @(posedge clk) begin
        if (loadValid && loadGrant) begin
            ctl <= nextCtl;
        end
    end

endmodule

//--- verilog/outputAlign.sv
module outputAlign
    import loadAlignPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  alignCtl_t ctl,
    input  logic      ctlValid,
    input  line_t     evenData,
    input  line_t     oddData,
    output result_t   result,
    output logic      resultValid
);

    line_t   firstLine;
    line_t   secondLine;
    line_t   rotated;
    result_t merged;
    result_t sized;
    logic    topBit;
    logic    extBit;

    // Swap into address order.
    assign firstLine  = ctl.oddFirst ? oddData : evenData;
    assign secondLine = ctl.oddFirst ? evenData : oddData;

    // Byte rotate right by the offset.
    always_comb begin
        rotated = line_t'({firstLine, firstLine} >> {ctl.offset, 3'b000});
    end

    always_comb begin
        merged = rotated[63:0];
        for (int b = 0; b < 8; b++) begin
            if (ctl.needP1 && (b + ctl.offset) >= LINE_BYTES) begin
                merged[8*b +: 8] = secondLine[8*(b + ctl.offset - LINE_BYTES) +: 8];
            end
        end
    end

    always_comb begin
        case (ctl.size)
            sizeByte: topBit = merged[7];
            sizeHalf: topBit = merged[15];
            sizeWord: topBit = merged[31];
            default:  topBit = merged[63];
        endcase
        extBit = ctl.signExt && topBit; // Zero fill when signExt is clear.
        case (ctl.size)
            sizeByte:   sized = {{56{extBit}}, merged[7:0]};
            sizeHalf:   sized = {{48{extBit}}, merged[15:0]};
            sizeWord:   sized = {{32{extBit}}, merged[31:0]};
            sizeDouble: sized = merged;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= ctlValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctlValid) begin
            result <= sized;
        end
    end

endmodule

//--- verilog/loadAlignTop.sv
module loadAlignTop
    import loadAlignPkg::*;
#(
    parameter int bankLines = 64
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     PSEL,
    input  logic     PENABLE,
    input  logic     PWRITE,
    input  word_t    PADDR,
    input  word_t    PWDATA,
    output word_t    PRDATA,
    output logic     PREADY,
    output logic     PSLVERR,
    input  logic     loadValid,
    input  loadReq_t loadReq,
    output logic     loadReady,
    output logic     resultValid,
    output result_t  result
);

    logic      loadAsk, apbAsk, loadGrant, apbGrant;
    bankReq_t  loadEven, loadOdd, apbEven, apbOdd;
    bankReq_t  evenReq, oddReq;
    logic      evenValid, oddValid;
    line_t     evenData, oddData;
    alignCtl_t ctl;
    logic      ctlValid;

    apbLineFill #(.bankLines(bankLines)) apbFill (
        .clk, .rstN, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .PRDATA, .PREADY, .PSLVERR,
        .apbAsk, .apbGrant, .apbEven, .apbOdd, .evenData, .oddData
    );

    loadIssue #(.bankLines(bankLines)) issue (
        .clk, .rstN, .loadValid, .loadReq, .loadReady,
        .loadAsk, .loadGrant, .loadEven, .loadOdd, .ctl, .ctlValid
    );

    bankArbiter arbiter (
        .clk, .rstN, .loadAsk, .apbAsk, .loadEven, .loadOdd, .apbEven, .apbOdd,
        .loadGrant, .apbGrant, .evenReq, .oddReq, .evenValid, .oddValid
    );

    lineBank #(.bankLines(bankLines)) evenBank (
        .clk, .req(evenReq), .reqValid(evenValid), .rdata(evenData)
    );

    lineBank #(.bankLines(bankLines)) oddBank (
        .clk, .req(oddReq), .reqValid(oddValid), .rdata(oddData)
    );

    outputAlign align (
        .clk, .rstN, .ctl, .ctlValid, .evenData, .oddData, .result, .resultValid
    );

endmodule

//--- dv/loadAlign_asserts.sv
module loadAlignAsserts (
    input logic clk,
    input logic rstN,
    input logic loadValid,
    input logic loadReady,
    input logic loadGrant,
    input logic apbGrant,
    input logic resultValid,
    input logic PSEL,
    input logic PENABLE,
    input logic PREADY,
    input logic PSLVERR
);
    timeunit 1ns;
    timeprecision 1ps;

    grantExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(loadGrant && apbGrant)) else $error("Both peers granted in one cycle.");

    resultTiming: assert property (@(posedge clk) disable iff (!rstN)
        loadValid && loadReady |-> ##2 resultValid) else $error("Result not 2 cycles later.");

    noStrayResult: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> $past(loadValid && loadReady, 2)) else $error("Result without a load.");

    readyInAccess: assert property (@(posedge clk) disable iff (!rstN)
        PREADY |-> PSEL && PENABLE) else $error("PREADY outside the access phase.");

    // Registered outputs need one reset edge to settle.
    quietInReset: assert property (@(posedge clk)
        !rstN && $past(!rstN) |-> !loadReady && !resultValid && !PREADY && !PSLVERR
            && !loadGrant && !apbGrant) else $error("Outputs active during reset.");

endmodule

bind loadAlignTop loadAlignAsserts asserts (.*);

//--- dv/loadAlignTb.sv
module loadAlignTb
    import loadAlignPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int storeBytes = 2048;
    localparam int testCycles = 6000; // Rough sum over all tests.
    localparam int marginCycles = 2000;

    logic clk = 1'b0;
    logic rstN, PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
    word_t PADDR, PWDATA, PRDATA;
    logic loadValid, loadReady, resultValid;
    loadReq_t loadReq;
    result_t result;

    logic [7:0] store [storeBytes];
    logic [31:0] seed = 32'h67d6_186d;
    result_t expQ [$];

    loadAlignTop #(.bankLines(64)) DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("FAILED %s got %h expected %h", name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic word_t modelWord(input word_t addr);
        if (addr >= storeBytes) return '0;
        return {store[addr+3], store[addr+2], store[addr+1], store[addr]};
    endfunction

    // Bytes pAddr upward, little endian, filled above with sign or zeros.
    function automatic result_t expectLoad(input loadReq_t r);
        int n;
        result_t v;
        logic fill;
        n = 1 << r.size;
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = store[(r.pAddr + i) % storeBytes];
        fill = r.signExt && v[8*n-1];
        for (int i = 8 * n; i < 64; i++) v[i] = fill;
        return v;
    endfunction

    task automatic apbAccess(input logic write, input word_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        PSEL = 1'b1;
        PWRITE = write;
        PADDR = addr;
        PWDATA = wdata;
        @(negedge clk);
        PENABLE = 1'b1;
        #1;
        while (!PREADY) begin
            @(negedge clk);
            #1;
            waits++;
            assert (waits < 20) else stopRun("APB access never completed.");
        end
        rdata = PRDATA;
        err = PSLVERR;
        if (write && !err) begin
            for (int b = 0; b < 4; b++) store[addr+b] = wdata[8*b +: 8];
        end
        @(negedge clk);
        PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic writeWord(input word_t addr, input word_t data, input logic expErr);
        word_t rd;
        logic err;
        apbAccess(1'b1, addr, data, rd, err);
        assert (err == expErr) else mismatch("PSLVERR", err, expErr);
    endtask

    task automatic readWord(input word_t addr, input logic expErr);
        word_t rd;
        word_t exp;
        logic err;
        exp = modelWord(addr);
        apbAccess(1'b0, addr, '0, rd, err);
        assert (err == expErr) else mismatch("PSLVERR", err, expErr);
        assert (rd == exp) else mismatch("PRDATA", rd, exp);
    endtask

    // Leaves loadValid high so the caller can chain loads cycle by cycle.
    task automatic issueLoad(input pAddr_t addr, input loadSize_t size, input logic signExt);
        @(negedge clk);
        loadValid = 1'b1;
        loadReq = '{pAddr: addr, size: size, signExt: signExt};
        #2;
        while (!loadReady) begin
            @(negedge clk);
            #2;
        end
        expQ.push_back(expectLoad(loadReq));
    endtask

    task automatic finishLoads();
        @(negedge clk);
        loadValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (rstN && resultValid) begin
            assert (expQ.size() > 0) else stopRun("Result arrived with no load pending.");
            assert (result == expQ[0]) else mismatch("result", result, expQ[0]);
            void'(expQ.pop_front());
        end
    end

    task automatic fillAndReadback();
        for (int w = 0; w < storeBytes / 4; w++) begin
            seed = xorshift32(seed);
            writeWord(w * 4, seed, 1'b0);
        end
        for (int i = 0; i < 32; i++) begin
            seed = xorshift32(seed);
            readWord({seed[10:2], 2'b00}, 1'b0);
        end
    endtask

    task automatic loadsInLine();
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off <= 16 - (1 << s); off++) begin
                seed = xorshift32(seed);
                issueLoad({seed[10:4], 4'(off)}, loadSize_t'(s), 1'b0);
                finishLoads();
            end
        end
    endtask

    task automatic crossingLoads();
        int lines [3] = '{4, 5, 127}; // Even to odd, odd to even, last row wrap.
        for (int l = 0; l < 3; l++) begin
            for (int s = 1; s < 4; s++) begin
                for (int off = 17 - (1 << s); off < 16; off++) begin
                    issueLoad(pAddr_t'(lines[l] * 16 + off), loadSize_t'(s), 1'b0);
                    finishLoads();
                end
            end
        end
    endtask

    task automatic signLoads();
        writeWord(32'h100, 32'h8081_8283, 1'b0);
        writeWord(32'h104, 32'h7f7e_7d7c, 1'b0);
        for (int s = 0; s < 4; s++) begin
            for (int e = 0; e < 2; e++) begin
                issueLoad(15'h104 - 15'(1 << s), loadSize_t'(s), e[0]); // Top byte 0x80.
                issueLoad(15'h108 - 15'(1 << s), loadSize_t'(s), e[0]); // Top byte 0x7f.
                finishLoads();
            end
        end
    endtask

    task automatic contention();
        word_t wAddr [8];
        word_t wData [8];
        for (int i = 0; i < 8; i++) begin
            seed = xorshift32(seed);
            wAddr[i] = {seed[10:2], 2'b00};
            wData[i] = xorshift32(seed);
        end
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    seed = xorshift32(seed);
                    issueLoad(pAddr_t'(seed[10:0]), loadSize_t'(seed[12:11]), seed[13]);
                end
                finishLoads();
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    writeWord(wAddr[i], wData[i], 1'b0);
                end
            end
        join
    endtask

    task automatic outOfRange();
        writeWord(32'h800, 32'hdead_beef, 1'b1);
        writeWord(32'hffff_fffc, 32'h1234_5678, 1'b1);
        readWord(32'h800, 1'b1);
        readWord(32'h0, 1'b0); // Index 0x800 must not alias onto word 0.
        readWord(32'h7fc, 1'b0);
    endtask

    initial begin
        #((testCycles + marginCycles) * 10);
        $display("Timeout: the tests did not finish in the expected time.");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        rstN = 1'b0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        loadValid = 1'b0;
        loadReq = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        fillAndReadback();
        loadsInLine();
        crossingLoads();
        signLoads();
        contention();
        outOfRange();
        repeat (4) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- list.f
verilog/loadAlignPkg.sv
verilog/lineBank.sv
verilog/bankArbiter.sv
verilog/apbLineFill.sv
verilog/loadIssue.sv
verilog/outputAlign.sv
verilog/loadAlignTop.sv
dv/loadAlign_asserts.sv
dv/loadAlignTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= loadAlignTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)
